//--- source/soc_pkg.sv
// **************************************************
// shared definitions of the reduced soc
// widths, address map, word types, fsm state enums
// **************************************************

package soc_pkg;

  // word address and data widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // address bit 15 picks peripherals over l2
  localparam int unsigned PERIPH_BIT = 15;

  // l2 depth, only the low 8 address bits decode
  localparam int unsigned L2_WORDS = 256;

  // result slot of cluster 0, cluster i uses base plus i
  localparam logic [7:0] RESULT_BASE = 8'hF0;

  // peripheral register offsets
  localparam logic [PERIPH_BIT-1:0] PERIPH_SCRATCH_ADDR = PERIPH_BIT'(0);
  localparam logic [PERIPH_BIT-1:0] PERIPH_EOC_CNT_ADDR = PERIPH_BIT'(1);

  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT,
    WRITE,
    DONE
  } cluster_state_e;

  typedef enum logic [1:0] {
    ARB,
    ISSUE,
    RESP
  } bus_state_e;

endpackage

//--- source/soc_cluster.sv
// **************************************************
// compute cluster engine
// reads its l2 block, sums the words and writes
// the sum to its result slot, then pulses eoc
// **************************************************

`timescale 1ns/1ps

module soc_cluster import soc_pkg::*; #(
  parameter int unsigned CLUSTER_ID  = 0,
  parameter int unsigned BLOCK_WORDS = 8
) (
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  fetch_en_i,
  output logic  busy_o,
  output logic  eoc_o,

  output logic  req_valid_o,
  input  logic  req_ready_i,
  output addr_t req_addr_o,
  output logic  req_we_o,
  output word_t req_wdata_o,
  input  logic  rsp_valid_i,
  input  word_t rsp_rdata_i
);

  localparam int unsigned IDX_W = $clog2(BLOCK_WORDS + 1);

  // block and result slot of this cluster
  localparam addr_t BLOCK_BASE  = addr_t'(CLUSTER_ID * BLOCK_WORDS);
  localparam addr_t RESULT_ADDR = addr_t'(RESULT_BASE) + addr_t'(CLUSTER_ID);

  // index of the last read, and the index seen while the write is in flight
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BLOCK_WORDS - 1);
  localparam logic [IDX_W-1:0] WR_IDX   = IDX_W'(BLOCK_WORDS);

  cluster_state_e   state_q, state_d;
  logic             fetch_q;
  logic             start;
  logic [IDX_W-1:0] idx_q, idx_d;
  word_t            acc_q, acc_d;

  // rising edge of fetch enable
  assign start = fetch_en_i & ~fetch_q;

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    acc_d   = acc_q;
    case (state_q)
      IDLE: begin
        if (start) begin
          state_d = READ;
          idx_d   = '0;
          acc_d   = '0;
        end
      end
      READ: begin
        if (req_ready_i) begin
          state_d = WAIT;
        end
      end
      WRITE: begin
        if (req_ready_i) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (rsp_valid_i) begin
          if (idx_q == WR_IDX) begin
            // write of the sum acknowledged
            state_d = DONE;
          end else begin
            acc_d   = acc_q + rsp_rdata_i;
            idx_d   = idx_q + 1'b1;
            state_d = (idx_q == LAST_IDX) ? WRITE : READ;
          end
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      fetch_q <= 1'b0;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      fetch_q <= fetch_en_i;
      idx_q   <= idx_d;
    end
  end

  // running sum of the block words
  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  assign busy_o = (state_q == READ) || (state_q == WAIT) || (state_q == WRITE);
  assign eoc_o  = (state_q == DONE);

  // request held stable by the state until accepted
  assign req_valid_o = (state_q == READ) || (state_q == WRITE);
  assign req_we_o    = (state_q == WRITE);
  assign req_addr_o  = (state_q == WRITE) ? RESULT_ADDR : BLOCK_BASE + addr_t'(idx_q);
  assign req_wdata_o = acc_q;

endmodule

//--- source/soc_bus.sv
// **************************************************
// soc bus, one transaction at a time
// round-robin arbiter over clusters and host,
// decode to l2 or peripherals on PERIPH_BIT
// **************************************************

`timescale 1ns/1ps

module soc_bus import soc_pkg::*; #(
  parameter int unsigned N_CLUSTERS = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // masters, host at index N_CLUSTERS
  input  logic  [N_CLUSTERS:0] mst_req_valid_i,
  output logic  [N_CLUSTERS:0] mst_req_ready_o,
  input  addr_t [N_CLUSTERS:0] mst_req_addr_i,
  input  logic  [N_CLUSTERS:0] mst_req_we_i,
  input  word_t [N_CLUSTERS:0] mst_req_wdata_i,
  output logic  [N_CLUSTERS:0] mst_rsp_valid_o,
  output word_t [N_CLUSTERS:0] mst_rsp_rdata_o,

  output logic                 l2_req_valid_o,
  output addr_t                l2_req_addr_o,
  output logic                 l2_req_we_o,
  output word_t                l2_req_wdata_o,
  input  logic                 l2_rsp_valid_i,
  input  word_t                l2_rsp_rdata_i,

  output logic                 per_req_valid_o,
  output addr_t                per_req_addr_o,
  output logic                 per_req_we_o,
  output word_t                per_req_wdata_o,
  input  logic                 per_rsp_valid_i,
  input  word_t                per_rsp_rdata_i
);

  localparam int unsigned N_MST = N_CLUSTERS + 1;
  localparam int unsigned GNT_W = $clog2(N_MST);

  bus_state_e       state_q, state_d;
  logic [GNT_W-1:0] grant_q, grant_d;
  logic             found;
  logic             fwd_q;
  addr_t            addr_q;
  logic             we_q;
  word_t            wdata_q;
  logic             per_sel;
  logic             slv_rsp_valid;
  word_t            slv_rsp_rdata;

  // round robin, search starts one after the last grant
  always_comb begin
    int unsigned idx;
    idx     = 0;
    found   = 1'b0;
    grant_d = grant_q;
    for (int unsigned i = 1; i <= N_MST; i++) begin
      idx = int'(grant_q) + i;
      if (idx >= N_MST) begin
        idx = idx - N_MST;
      end
      if (!found && mst_req_valid_i[idx]) begin
        found   = 1'b1;
        grant_d = GNT_W'(idx);
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB:     state_d = found ? ISSUE : ARB;
      ISSUE:   state_d = RESP;
      RESP:    state_d = slv_rsp_valid ? ARB : RESP;
      default: state_d = ARB;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ARB;
      grant_q <= '0;
      fwd_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == ARB) && found) begin
        grant_q <= grant_d;
      end
      // slave sees the request for one cycle after ISSUE
      fwd_q <= (state_q == ISSUE);
    end
  end

  // capture the granted request
  always_ff @(posedge clk_i) begin
    if (state_q == ISSUE) begin
      addr_q  <= mst_req_addr_i[grant_q];
      we_q    <= mst_req_we_i[grant_q];
      wdata_q <= mst_req_wdata_i[grant_q];
    end
  end

  assign per_sel = addr_q[PERIPH_BIT];

  assign l2_req_valid_o  = fwd_q & ~per_sel;
  assign l2_req_addr_o   = addr_q;
  assign l2_req_we_o     = we_q;
  assign l2_req_wdata_o  = wdata_q;

  assign per_req_valid_o = fwd_q & per_sel;
  assign per_req_addr_o  = addr_q;
  assign per_req_we_o    = we_q;
  assign per_req_wdata_o = wdata_q;

  assign slv_rsp_valid = per_sel ? per_rsp_valid_i : l2_rsp_valid_i;
  assign slv_rsp_rdata = per_sel ? per_rsp_rdata_i : l2_rsp_rdata_i;

  always_comb begin
    mst_req_ready_o = '0;
    mst_rsp_valid_o = '0;
    if (state_q == ISSUE) begin
      mst_req_ready_o[grant_q] = 1'b1;
    end
    if (state_q == RESP) begin
      mst_rsp_valid_o[grant_q] = slv_rsp_valid;
    end
  end

  // read data goes to every master, only the granted one sees valid
  assign mst_rsp_rdata_o = {N_MST{slv_rsp_rdata}};

endmodule

//--- source/l2_mem.sv
// **************************************************
// l2 memory, single port word array
// one-cycle read response
// **************************************************

`timescale 1ns/1ps

module l2_mem import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  input  logic  req_we_i,
  input  word_t req_wdata_i,
  output logic  rsp_valid_o,
  output word_t rsp_rdata_o
);

  localparam int unsigned IDX_W = $clog2(L2_WORDS);

  word_t            mem [L2_WORDS];
  logic [IDX_W-1:0] idx;

  // upper address bits are ignored
  assign idx = req_addr_i[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      if (req_we_i) begin
        mem[idx] <= req_wdata_i;
      end else begin
        rsp_rdata_o <= mem[idx];
      end
    end
  end

  // every request, write or read, is answered next cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
    end
  end

endmodule

//--- source/soc_periph.sv
// **************************************************
// soc peripherals
// scratch register and eoc event counter
// **************************************************

`timescale 1ns/1ps

module soc_periph import soc_pkg::*; #(
  parameter int unsigned N_CLUSTERS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  addr_t                 req_addr_i,
  input  logic                  req_we_i,
  input  word_t                 req_wdata_i,
  output logic                  rsp_valid_o,
  output word_t                 rsp_rdata_o,
  input  logic [N_CLUSTERS-1:0] eoc_i
);

  logic [PERIPH_BIT-1:0] offset;
  word_t                 scratch_q;
  word_t                 eoc_cnt_q;
  word_t                 eoc_inc;
  word_t                 rd_data;

  assign offset = req_addr_i[PERIPH_BIT-1:0];

  // number of eoc pulses this cycle
  always_comb begin
    eoc_inc = '0;
    for (int unsigned i = 0; i < N_CLUSTERS; i++) begin
      eoc_inc = eoc_inc + word_t'(eoc_i[i]);
    end
  end

  always_comb begin
    case (offset)
      PERIPH_SCRATCH_ADDR: rd_data = scratch_q;
      PERIPH_EOC_CNT_ADDR: rd_data = eoc_cnt_q;
      default:             rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scratch_q   <= '0;
      eoc_cnt_q   <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
      eoc_cnt_q   <= eoc_cnt_q + eoc_inc;
      // counter is read-only, writes elsewhere are dropped
      if (req_valid_i && req_we_i && (offset == PERIPH_SCRATCH_ADDR)) begin
        scratch_q <= req_wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && !req_we_i) begin
      rsp_rdata_o <= rd_data;
    end
  end

endmodule

//--- source/pulp_soc.sv
// **************************************************
// soc top level
// clusters and host on the soc bus, l2 and periphs
// **************************************************

`timescale 1ns/1ps

module pulp_soc import soc_pkg::*; #(
  parameter int unsigned N_CLUSTERS  = 2,
  parameter int unsigned BLOCK_WORDS = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // cluster control
  input  logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [N_CLUSTERS-1:0] cl_eoc_o,
  output logic [N_CLUSTERS-1:0] cl_busy_o,

  // host port
  input  logic                  ext_req_valid_i,
  output logic                  ext_req_ready_o,
  input  addr_t                 ext_req_addr_i,
  input  logic                  ext_req_we_i,
  input  word_t                 ext_req_wdata_i,
  output logic                  ext_rsp_valid_o,
  output word_t                 ext_rsp_rdata_o
);

  logic  [N_CLUSTERS-1:0] cl_req_valid;
  logic  [N_CLUSTERS-1:0] cl_req_ready;
  addr_t [N_CLUSTERS-1:0] cl_req_addr;
  logic  [N_CLUSTERS-1:0] cl_req_we;
  word_t [N_CLUSTERS-1:0] cl_req_wdata;
  logic  [N_CLUSTERS-1:0] cl_rsp_valid;
  word_t [N_CLUSTERS-1:0] cl_rsp_rdata;

  logic  l2_req_valid, l2_req_we, l2_rsp_valid;
  addr_t l2_req_addr;
  word_t l2_req_wdata, l2_rsp_rdata;

  logic  per_req_valid, per_req_we, per_rsp_valid;
  addr_t per_req_addr;
  word_t per_req_wdata, per_rsp_rdata;

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_clusters
    soc_cluster #(
      .CLUSTER_ID  (i),
      .BLOCK_WORDS (BLOCK_WORDS)
    ) i_cluster (
      .clk_i,
      .rst_n_i,
      .fetch_en_i  (cl_fetch_en_i[i]),
      .busy_o      (cl_busy_o[i]),
      .eoc_o       (cl_eoc_o[i]),
      .req_valid_o (cl_req_valid[i]),
      .req_ready_i (cl_req_ready[i]),
      .req_addr_o  (cl_req_addr[i]),
      .req_we_o    (cl_req_we[i]),
      .req_wdata_o (cl_req_wdata[i]),
      .rsp_valid_i (cl_rsp_valid[i]),
      .rsp_rdata_i (cl_rsp_rdata[i])
    );
  end

  // host is the last master
  soc_bus #(
    .N_CLUSTERS (N_CLUSTERS)
  ) i_soc_bus (
    .clk_i,
    .rst_n_i,
    .mst_req_valid_i ({ext_req_valid_i, cl_req_valid}),
    .mst_req_ready_o ({ext_req_ready_o, cl_req_ready}),
    .mst_req_addr_i  ({ext_req_addr_i, cl_req_addr}),
    .mst_req_we_i    ({ext_req_we_i, cl_req_we}),
    .mst_req_wdata_i ({ext_req_wdata_i, cl_req_wdata}),
    .mst_rsp_valid_o ({ext_rsp_valid_o, cl_rsp_valid}),
    .mst_rsp_rdata_o ({ext_rsp_rdata_o, cl_rsp_rdata}),
    .l2_req_valid_o  (l2_req_valid),
    .l2_req_addr_o   (l2_req_addr),
    .l2_req_we_o     (l2_req_we),
    .l2_req_wdata_o  (l2_req_wdata),
    .l2_rsp_valid_i  (l2_rsp_valid),
    .l2_rsp_rdata_i  (l2_rsp_rdata),
    .per_req_valid_o (per_req_valid),
    .per_req_addr_o  (per_req_addr),
    .per_req_we_o    (per_req_we),
    .per_req_wdata_o (per_req_wdata),
    .per_rsp_valid_i (per_rsp_valid),
    .per_rsp_rdata_i (per_rsp_rdata)
  );

  l2_mem i_l2_mem (
    .clk_i,
    .rst_n_i,
    .req_valid_i (l2_req_valid),
    .req_addr_i  (l2_req_addr),
    .req_we_i    (l2_req_we),
    .req_wdata_i (l2_req_wdata),
    .rsp_valid_o (l2_rsp_valid),
    .rsp_rdata_o (l2_rsp_rdata)
  );

  soc_periph #(
    .N_CLUSTERS (N_CLUSTERS)
  ) i_periphs (
    .clk_i,
    .rst_n_i,
    .req_valid_i (per_req_valid),
    .req_addr_i  (per_req_addr),
    .req_we_i    (per_req_we),
    .req_wdata_i (per_req_wdata),
    .rsp_valid_o (per_rsp_valid),
    .rsp_rdata_o (per_rsp_rdata),
    .eoc_i       (cl_eoc_o)
  );

endmodule

//--- testbench/tb_clk_gen.sv
// **************************************************
// testbench clock and reset generator
// **************************************************

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 8,
  parameter int unsigned RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

  // release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- testbench/pulp_soc_checker.sv
// **************************************************
// protocol assertions on the soc top level
// eoc pulse width, busy fall, host handshake
// **************************************************

`timescale 1ns/1ps

module pulp_soc_checker #(
  parameter int unsigned N_CLUSTERS = 2
) (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic [N_CLUSTERS-1:0] cl_eoc_o,
  input logic [N_CLUSTERS-1:0] cl_busy_o,
  input logic                  ext_req_valid_i,
  input logic                  ext_req_ready_o,
  input logic                  ext_rsp_valid_o
);

  logic [1:0] outstanding_q;

  // accepted host requests still waiting for a response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= '0;
    end else if (ext_req_valid_i && ext_req_ready_o && !ext_rsp_valid_o) begin
      outstanding_q <= outstanding_q + 2'd1;
    end else if (ext_rsp_valid_o && !(ext_req_valid_i && ext_req_ready_o)) begin
      outstanding_q <= outstanding_q - 2'd1;
    end
  end

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_cluster_checks
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cl_eoc_o[i] |=> !cl_eoc_o[i])
      else $error("eoc of cluster %0d is longer than one cycle", i);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(cl_busy_o[i]) |-> cl_eoc_o[i])
      else $error("busy of cluster %0d fell without eoc", i);
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ext_rsp_valid_o) |-> (outstanding_q != 2'd0))
    else $error("host response without an accepted host request");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_req_ready_o |-> ext_req_valid_i)
    else $error("host ready high while host valid is low");

endmodule

bind pulp_soc pulp_soc_checker #(
  .N_CLUSTERS (N_CLUSTERS)
) i_pulp_soc_checker (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .cl_eoc_o        (cl_eoc_o),
  .cl_busy_o       (cl_busy_o),
  .ext_req_valid_i (ext_req_valid_i),
  .ext_req_ready_o (ext_req_ready_o),
  .ext_rsp_valid_o (ext_rsp_valid_o)
);

//--- testbench/tb_pulp_soc.sv
// **************************************************
// testbench of the reduced soc
// host access tasks, l2 model, compare tasks,
// timeout and test summary
// **************************************************

`timescale 1ns/1ps

module tb_pulp_soc import soc_pkg::*; ();

  localparam int unsigned N_CLUSTERS  = 2;
  localparam int unsigned BLOCK_WORDS = 8;
  localparam int unsigned N_MST       = N_CLUSTERS + 1;
  localparam int unsigned N_RW        = 16;
  localparam int unsigned N_BG        = 12;

  localparam addr_t PERIPH_SEL   = addr_t'(1) << PERIPH_BIT;
  localparam addr_t SCRATCH_ADDR = PERIPH_SEL | addr_t'(PERIPH_SCRATCH_ADDR);
  localparam addr_t EOC_CNT_ADDR = PERIPH_SEL | addr_t'(PERIPH_EOC_CNT_ADDR);

  // arb, issue and two resp cycles per transaction
  localparam int unsigned TXN_CYCLES = 4;
  localparam int unsigned N_TXN = 1 + 2 * N_RW + 2 + (2 * BLOCK_WORDS + 2)
                                + N_CLUSTERS * (2 * BLOCK_WORDS + 2) + 2 * N_BG + 1;
  localparam int unsigned TIMEOUT_CYCLES = N_TXN * N_MST * TXN_CYCLES + 300;

  logic                  clk;
  logic                  rst_n;
  logic [N_CLUSTERS-1:0] cl_fetch_en;
  logic [N_CLUSTERS-1:0] cl_eoc;
  logic [N_CLUSTERS-1:0] cl_busy;
  logic                  ext_req_valid;
  logic                  ext_req_ready;
  addr_t                 ext_req_addr;
  logic                  ext_req_we;
  word_t                 ext_req_wdata;
  logic                  ext_rsp_valid;
  word_t                 ext_rsp_rdata;

  // reference model
  word_t       model_mem [L2_WORDS];
  word_t       model_scratch;
  int unsigned model_runs = 0;

  logic [31:0] lfsr_q;
  int unsigned cycles = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned errors_at_start = 0;
  int unsigned test_num = 0;
  int unsigned tests_ok = 0;

  tb_clk_gen #(
    .PERIOD_NS  (8),
    .RST_CYCLES (5)
  ) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  pulp_soc #(
    .N_CLUSTERS  (N_CLUSTERS),
    .BLOCK_WORDS (BLOCK_WORDS)
  ) pulp_soc_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .cl_fetch_en_i   (cl_fetch_en),
    .cl_eoc_o        (cl_eoc),
    .cl_busy_o       (cl_busy),
    .ext_req_valid_i (ext_req_valid),
    .ext_req_ready_o (ext_req_ready),
    .ext_req_addr_i  (ext_req_addr),
    .ext_req_we_i    (ext_req_we),
    .ext_req_wdata_i (ext_req_wdata),
    .ext_rsp_valid_o (ext_rsp_valid),
    .ext_rsp_rdata_o (ext_rsp_rdata)
  );

  // galois lfsr, taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hD000_0001;
    end
    return s >> 1;
  endfunction

  function automatic word_t rand_bits(input int unsigned nbits);
    word_t val;
    val = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[DATA_W-2:0], lfsr_q[0]};
    end
    return val;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input word_t got, input int unsigned exp);
    checks++;
    if (got !== word_t'(exp)) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (errors == errors_at_start) begin
      tests_ok++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_num, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // one host transaction, request held until ready, then wait for the response
  task automatic host_access(input addr_t addr, input logic we, input word_t wdata,
                             output word_t rdata);
    @(negedge clk);
    ext_req_valid = 1'b1;
    ext_req_addr  = addr;
    ext_req_we    = we;
    ext_req_wdata = wdata;
    do begin
      @(negedge clk);
    end while (!ext_req_ready);
    @(negedge clk);
    ext_req_valid = 1'b0;
    while (!ext_rsp_valid) begin
      @(negedge clk);
    end
    rdata = ext_rsp_rdata;
  endtask

  task automatic host_write(input addr_t addr, input word_t data);
    word_t unused;
    host_access(addr, 1'b1, data, unused);
  endtask

  task automatic host_read(input addr_t addr, output word_t data);
    host_access(addr, 1'b0, '0, data);
  endtask

  task automatic load_block(input int unsigned cl);
    word_t data;
    for (int unsigned k = 0; k < BLOCK_WORDS; k++) begin
      data = rand_bits(DATA_W);
      model_mem[cl * BLOCK_WORDS + k] = data;
      host_write(addr_t'(cl * BLOCK_WORDS + k), data);
    end
  endtask

  function automatic word_t block_sum(input int unsigned cl);
    word_t sum;
    sum = '0;
    for (int unsigned k = 0; k < BLOCK_WORDS; k++) begin
      sum = sum + model_mem[cl * BLOCK_WORDS + k];
    end
    return sum;
  endfunction

  task automatic reset_values();
    word_t rdata;
    for (int unsigned i = 0; i < N_CLUSTERS; i++) begin
      check_level($sformatf("cl_busy_o[%0d]", i), cl_busy[i], 1'b0);
      check_level($sformatf("cl_eoc_o[%0d]", i), cl_eoc[i], 1'b0);
    end
    check_level("ext_rsp_valid_o", ext_rsp_valid, 1'b0);
    host_read(EOC_CNT_ADDR, rdata);
    check_count("eoc counter", rdata, 0);
    end_test("reset values");
  endtask

  task automatic l2_write_read();
    addr_t addr;
    word_t data;
    word_t rdata;
    for (int unsigned n = 0; n < N_RW; n++) begin
      addr = addr_t'(rand_bits(8) % RESULT_BASE);
      data = rand_bits(DATA_W);
      model_mem[addr[7:0]] = data;
      host_write(addr, data);
      host_read(addr, rdata);
      check_word("ext_rsp_rdata_o", rdata, model_mem[addr[7:0]]);
    end
    end_test("l2 write and read");
  endtask

  task automatic scratch_roundtrip();
    word_t rdata;
    model_scratch = rand_bits(DATA_W);
    host_write(SCRATCH_ADDR, model_scratch);
    host_read(SCRATCH_ADDR, rdata);
    check_word("scratch register", rdata, model_scratch);
    end_test("scratch register");
  endtask

  task automatic single_cluster_sum();
    word_t sum;
    word_t rdata;
    logic  busy_gap;
    busy_gap = 1'b0;
    load_block(0);
    sum = block_sum(0);
    @(negedge clk);
    cl_fetch_en[0] = 1'b1;
    @(negedge clk);
    check_level("cl_busy_o[0]", cl_busy[0], 1'b1);
    do begin
      @(negedge clk);
      if (!cl_eoc[0] && !cl_busy[0]) begin
        busy_gap = 1'b1;
      end
    end while (!cl_eoc[0]);
    check_level("cl_busy_o[0] at eoc", cl_busy[0], 1'b0);
    if (busy_gap) begin
      errors++;
      $display("busy of cluster 0 went low before its eoc pulse");
    end
    cl_fetch_en[0] = 1'b0;
    model_mem[RESULT_BASE] = sum;
    model_runs++;
    host_read(addr_t'(RESULT_BASE), rdata);
    check_word("cluster 0 result", rdata, model_mem[RESULT_BASE]);
    end_test("single cluster sum");
  endtask

  task automatic parallel_clusters();
    addr_t                 bg_addr [N_BG];
    word_t                 sums [N_CLUSTERS];
    word_t                 data;
    word_t                 rdata;
    logic [N_CLUSTERS-1:0] seen;
    for (int unsigned cl = 0; cl < N_CLUSTERS; cl++) begin
      load_block(cl);
      sums[cl] = block_sum(cl);
    end
    // host traffic lives between the blocks and the result slots
    for (int unsigned k = 0; k < N_BG; k++) begin
      bg_addr[k] = addr_t'(N_CLUSTERS * BLOCK_WORDS
                 + rand_bits(8) % (RESULT_BASE - N_CLUSTERS * BLOCK_WORDS));
      data = rand_bits(DATA_W);
      model_mem[bg_addr[k][7:0]] = data;
      host_write(bg_addr[k], data);
    end
    @(negedge clk);
    cl_fetch_en = '1;
    fork
      begin
        for (int unsigned k = 0; k < N_BG; k++) begin
          host_read(bg_addr[k], rdata);
          check_word("ext_rsp_rdata_o", rdata, model_mem[bg_addr[k][7:0]]);
        end
      end
      begin
        seen = '0;
        while (seen != '1) begin
          @(negedge clk);
          seen = seen | cl_eoc;
        end
      end
    join
    cl_fetch_en = '0;
    for (int unsigned cl = 0; cl < N_CLUSTERS; cl++) begin
      model_mem[RESULT_BASE + cl] = sums[cl];
      model_runs++;
      host_read(addr_t'(RESULT_BASE + cl), rdata);
      check_word($sformatf("cluster %0d result", cl), rdata, model_mem[RESULT_BASE + cl]);
    end
    end_test("parallel clusters");
  endtask

  task automatic eoc_total();
    word_t rdata;
    host_read(EOC_CNT_ADDR, rdata);
    check_count("eoc counter", rdata, model_runs);
    end_test("eoc count");
  endtask

  initial begin
    cl_fetch_en   = '0;
    ext_req_valid = 1'b0;
    ext_req_addr  = '0;
    ext_req_we    = 1'b0;
    ext_req_wdata = '0;
    lfsr_q        = 32'h67fd;
    wait (rst_n === 1'b1);
    @(negedge clk);
    reset_values();
    l2_write_read();
    scratch_roundtrip();
    single_cluster_sum();
    parallel_clusters();
    eoc_total();
    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             test_num, tests_ok, test_num - tests_ok, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // run limit from the transaction count at worst bus latency
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule

//--- tb.f
source/soc_pkg.sv
source/soc_cluster.sv
source/soc_bus.sv
source/l2_mem.sv
source/soc_periph.sv
source/pulp_soc.sv
testbench/tb_clk_gen.sv
testbench/pulp_soc_checker.sv
testbench/tb_pulp_soc.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the soc testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pulp_soc -f tb.f; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_pulp_soc)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" <<< "$out"; then
  exit 0
fi

echo "simulation did not pass"
exit 1
